//--- hw/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and address width
`define CORE_XLEN 32

// register index width
`define CORE_REG_ADDR_W 5

// first fetch address
`define CORE_RESET_PC 32'h0000_0000

// data memory size in words
`define CORE_DMEM_DEPTH 64

// custom opcode that stops the core
`define CORE_TRAP_OPCODE 7'h6b

`endif

//--- hw/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [`CORE_REG_ADDR_W-1:0] reg_addr_t;

  typedef enum logic {
    ALU_ADD = 1'b0,
    ALU_SUB = 1'b1
  } alu_op_e;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_e;

  // where an execute operand comes from
  typedef enum logic [1:0] {
    FWD_REG    = 2'd0,
    FWD_EX_MEM = 2'd1,
    FWD_MEM_WB = 2'd2
  } fwd_sel_e;

  typedef struct packed {
    word_t pc;
    inst_t inst;
  } if_id_t;

  typedef struct packed {
    word_t     pc;
    inst_t     inst;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    logic      use_imm;
    alu_op_e   alu_op;
    mem_op_e   mem_op;
    logic      branch;
    reg_addr_t rd;
    logic      rd_we;
    logic      trap;
  } id_ex_t;

  typedef struct packed {
    word_t     pc;
    inst_t     inst;
    word_t     alu_result;
    word_t     store_data;
    mem_op_e   mem_op;
    reg_addr_t rd;
    logic      rd_we;
    logic      trap;
  } ex_mem_t;

  // retired instruction, also the regfile write
  typedef struct packed {
    word_t     pc;
    inst_t     inst;
    reg_addr_t rd;
    logic      rd_we;
    word_t     rd_data;
    logic      trap;
  } commit_t;

endpackage

//--- hw/core_top.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module core_top (
  input  logic              clock,
  input  logic              reset,
  output core_pkg::word_t   imem_addr,
  input  core_pkg::inst_t   imem_data,
  output logic              commit_valid,
  output core_pkg::commit_t commit,
  output logic              halted
);

  logic                if_id_valid;
  core_pkg::if_id_t    if_id;
  logic                id_allowin;
  logic                redirect_valid;
  core_pkg::word_t     redirect_pc;
  core_pkg::reg_addr_t rs1_addr, rs2_addr;
  core_pkg::word_t     rs1_data, rs2_data;
  logic                stall;
  logic                id_ex_valid;
  core_pkg::id_ex_t    id_ex;
  logic                ex_allowin;
  core_pkg::fwd_sel_e  fwd_rs1, fwd_rs2;
  logic                ex_mem_valid;
  core_pkg::ex_mem_t   ex_mem;
  core_pkg::word_t     ex_mem_fwd;

  fetch_stage u_fetch_stage (
    .clock(clock), .reset(reset), .id_allowin(id_allowin),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc), .halted(halted),
    .imem_addr(imem_addr), .imem_data(imem_data),
    .if_id_valid(if_id_valid), .if_id(if_id)
  );

  // a taken branch flushes decode
  decode_stage u_decode_stage (
    .clock(clock), .reset(reset), .if_id_valid(if_id_valid), .if_id(if_id),
    .id_allowin(id_allowin), .flush(redirect_valid), .stall(stall),
    .ex_allowin(ex_allowin), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .id_ex_valid(id_ex_valid), .id_ex(id_ex)
  );

  // non-writing instructions carry rd 0
  regfile u_regfile (
    .clock(clock), .reset(reset), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wr_en(commit_valid), .wr_addr(commit.rd), .wr_data(commit.rd_data)
  );

  hazard_unit u_hazard_unit (
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .id_ex_valid(id_ex_valid), .id_ex(id_ex),
    .ex_mem_valid(ex_mem_valid), .ex_mem(ex_mem),
    .wb_valid(commit_valid), .wb(commit),
    .stall(stall), .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2)
  );

  execute_stage u_execute_stage (
    .clock(clock), .reset(reset), .id_ex_valid(id_ex_valid), .id_ex(id_ex),
    .ex_allowin(ex_allowin), .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2),
    .ex_mem_fwd(ex_mem_fwd), .wb_fwd(commit.rd_data),
    .ex_mem_valid(ex_mem_valid), .ex_mem(ex_mem),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
  );

  memory_stage u_memory_stage (
    .clock(clock), .reset(reset), .ex_mem_valid(ex_mem_valid), .ex_mem(ex_mem),
    .ex_mem_fwd(ex_mem_fwd), .commit_valid(commit_valid), .commit(commit),
    .halted(halted)
  );

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module decode_stage (
  input  logic                clock,
  input  logic                reset,
  input  logic                if_id_valid,
  input  core_pkg::if_id_t    if_id,
  output logic                id_allowin,
  input  logic                flush,
  input  logic                stall,
  input  logic                ex_allowin,
  output core_pkg::reg_addr_t rs1_addr,
  output core_pkg::reg_addr_t rs2_addr,
  input  core_pkg::word_t     rs1_data,
  input  core_pkg::word_t     rs2_data,
  output logic                id_ex_valid,
  output core_pkg::id_ex_t    id_ex
);

  localparam logic [6:0] OP_ALU    = 7'b0110011;
  localparam logic [6:0] OP_ALU_I  = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;

  core_pkg::inst_t  inst;
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic             is_rtype, is_addi, is_load, is_store, is_beq, is_trap;
  logic             uses_rs1, uses_rs2, writes_rd;
  logic             id_go;
  core_pkg::word_t  imm;
  core_pkg::id_ex_t dec;

  assign inst   = if_id.inst;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // add and sub only
  assign is_rtype = opcode == OP_ALU && funct3 == 3'b000 &&
                    (funct7 == 7'h00 || funct7 == 7'h20);
  assign is_addi  = opcode == OP_ALU_I && funct3 == 3'b000;
  assign is_load  = opcode == OP_LOAD && funct3 == 3'b010;
  assign is_store = opcode == OP_STORE && funct3 == 3'b010;
  assign is_beq   = opcode == OP_BRANCH && funct3 == 3'b000;
  assign is_trap  = opcode == `CORE_TRAP_OPCODE;

  assign uses_rs1  = is_rtype || is_addi || is_load || is_store || is_beq;
  assign uses_rs2  = is_rtype || is_store || is_beq;
  assign writes_rd = is_rtype || is_addi || is_load;

  // unused fields read as x0, so they never stall or forward
  assign rs1_addr = uses_rs1 ? inst[19:15] : '0;
  assign rs2_addr = uses_rs2 ? inst[24:20] : '0;

  always_comb begin
    if (is_store) begin
      imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    end else if (is_beq) begin
      imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    end else begin
      imm = {{20{inst[31]}}, inst[31:20]};
    end
  end

  always_comb begin
    dec.pc      = if_id.pc;
    dec.inst    = inst;
    dec.rs1     = rs1_addr;
    dec.rs2     = rs2_addr;
    dec.rs1_val = rs1_data;
    dec.rs2_val = rs2_data;
    dec.imm     = imm;
    dec.use_imm = is_addi || is_load || is_store;
    dec.alu_op  = (is_rtype && funct7[5]) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
    dec.mem_op  = is_load ? core_pkg::MEM_LOAD :
                  is_store ? core_pkg::MEM_STORE : core_pkg::MEM_NONE;
    dec.branch  = is_beq;
    dec.rd      = writes_rd ? inst[11:7] : '0;
    dec.rd_we   = writes_rd;
    dec.trap    = is_trap;
  end

  // stall leaves a bubble, flush drops the instruction
  assign id_go      = if_id_valid && !stall && !flush;
  assign id_allowin = !if_id_valid || (!stall && ex_allowin);

  always_ff @(posedge clock) begin
    if (reset) begin
      id_ex_valid <= 1'b0;
    end else if (ex_allowin) begin
      id_ex_valid <= id_go;
    end
  end

  always_ff @(posedge clock) begin
    if (ex_allowin && id_go) begin
      id_ex <= dec;
    end
  end

  // load in execute and taken branch in execute exclude each other
  assert property (@(posedge clock) disable iff (reset)
    (if_id_valid && ex_allowin) |-> !(stall && flush))
    else $error("decode saw stall and flush together");

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module execute_stage (
  input  logic               clock,
  input  logic               reset,
  input  logic               id_ex_valid,
  input  core_pkg::id_ex_t   id_ex,
  output logic               ex_allowin,
  input  core_pkg::fwd_sel_e fwd_rs1,
  input  core_pkg::fwd_sel_e fwd_rs2,
  input  core_pkg::word_t    ex_mem_fwd,
  input  core_pkg::word_t    wb_fwd,
  output logic               ex_mem_valid,
  output core_pkg::ex_mem_t  ex_mem,
  output logic               redirect_valid,
  output core_pkg::word_t    redirect_pc
);

  core_pkg::word_t op_a, op_b, alu_b, alu_result;
  logic            ex_done;

  function automatic core_pkg::word_t pick_operand(
    input core_pkg::fwd_sel_e sel,
    input core_pkg::word_t    reg_val,
    input core_pkg::word_t    mem_val,
    input core_pkg::word_t    wb_val
  );
    case (sel)
      core_pkg::FWD_EX_MEM: return mem_val;
      core_pkg::FWD_MEM_WB: return wb_val;
      default:              return reg_val;
    endcase
  endfunction

  always_comb begin
    op_a = pick_operand(fwd_rs1, id_ex.rs1_val, ex_mem_fwd, wb_fwd);
    op_b = pick_operand(fwd_rs2, id_ex.rs2_val, ex_mem_fwd, wb_fwd);
  end

  // also forms load and store addresses
  assign alu_b      = id_ex.use_imm ? id_ex.imm : op_b;
  assign alu_result = (id_ex.alu_op == core_pkg::ALU_SUB) ? op_a - alu_b : op_a + alu_b;

  assign redirect_valid = id_ex_valid && id_ex.branch && op_a == op_b;
  assign redirect_pc    = id_ex.pc + id_ex.imm;

  // memory never refuses
  assign ex_done    = id_ex_valid;
  assign ex_allowin = !id_ex_valid || ex_done;

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_mem_valid <= 1'b0;
    end else begin
      ex_mem_valid <= ex_done;
    end
  end

  always_ff @(posedge clock) begin
    if (ex_done) begin
      ex_mem <= '{pc: id_ex.pc, inst: id_ex.inst, alu_result: alu_result,
                  store_data: op_b, mem_op: id_ex.mem_op, rd: id_ex.rd,
                  rd_we: id_ex.rd_we, trap: id_ex.trap};
    end
  end

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module fetch_stage (
  input  logic             clock,
  input  logic             reset,
  input  logic             id_allowin,
  input  logic             redirect_valid,
  input  core_pkg::word_t  redirect_pc,
  input  logic             halted,
  output core_pkg::word_t  imem_addr,
  input  core_pkg::inst_t  imem_data,
  output logic             if_id_valid,
  output core_pkg::if_id_t if_id
);

  core_pkg::word_t pc;
  logic            fetch_go;

  assign imem_addr = pc;
  assign fetch_go  = !redirect_valid && id_allowin && !halted;

  // a redirect also kills the word fetched this cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      pc          <= `CORE_RESET_PC;
      if_id_valid <= 1'b0;
    end else if (redirect_valid) begin
      pc          <= redirect_pc;
      if_id_valid <= 1'b0;
    end else if (id_allowin) begin
      if_id_valid <= !halted;
      if (!halted) begin
        pc <= pc + core_pkg::word_t'(4);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_go) begin
      if_id <= '{pc: pc, inst: imem_data};
    end
  end

endmodule

//--- hw/hazard_unit.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module hazard_unit (
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  input  logic                id_ex_valid,
  input  core_pkg::id_ex_t    id_ex,
  input  logic                ex_mem_valid,
  input  core_pkg::ex_mem_t   ex_mem,
  input  logic                wb_valid,
  input  core_pkg::commit_t   wb,
  output logic                stall,
  output core_pkg::fwd_sel_e  fwd_rs1,
  output core_pkg::fwd_sel_e  fwd_rs2
);

  logic load_in_ex;
  logic mem_writes;
  logic wb_writes;

  // nearest producer first
  function automatic core_pkg::fwd_sel_e fwd_select(
    input core_pkg::reg_addr_t src,
    input logic                mem_hit,
    input core_pkg::reg_addr_t mem_rd,
    input logic                wb_hit,
    input core_pkg::reg_addr_t wb_rd
  );
    if (src == '0) begin
      return core_pkg::FWD_REG;
    end
    if (mem_hit && mem_rd == src) begin
      return core_pkg::FWD_EX_MEM;
    end
    if (wb_hit && wb_rd == src) begin
      return core_pkg::FWD_MEM_WB;
    end
    return core_pkg::FWD_REG;
  endfunction

  assign load_in_ex = id_ex_valid && id_ex.mem_op == core_pkg::MEM_LOAD && id_ex.rd != '0;
  assign mem_writes = ex_mem_valid && ex_mem.rd_we;
  assign wb_writes  = wb_valid && wb.rd_we;

  // loaded word is not ready until the memory cycle
  assign stall = load_in_ex && (id_ex.rd == rs1_addr || id_ex.rd == rs2_addr);

  always_comb begin
    fwd_rs1 = fwd_select(id_ex.rs1, mem_writes, ex_mem.rd, wb_writes, wb.rd);
    fwd_rs2 = fwd_select(id_ex.rs2, mem_writes, ex_mem.rd, wb_writes, wb.rd);
  end

endmodule

//--- hw/memory_stage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module memory_stage (
  input  logic              clock,
  input  logic              reset,
  input  logic              ex_mem_valid,
  input  core_pkg::ex_mem_t ex_mem,
  output core_pkg::word_t   ex_mem_fwd,
  output logic              commit_valid,
  output core_pkg::commit_t commit,
  output logic              halted
);

  localparam int DMEM_AW = $clog2(`CORE_DMEM_DEPTH);

  core_pkg::word_t    dmem [`CORE_DMEM_DEPTH];
  logic [DMEM_AW-1:0] dmem_index;
  core_pkg::word_t    load_data;
  logic               mem_go;

  // word index above the byte offset
  assign dmem_index = ex_mem.alu_result[DMEM_AW+1:2];
  assign load_data  = dmem[dmem_index];

  // nothing younger than the trap retires
  assign mem_go = ex_mem_valid && !halted;

  assign ex_mem_fwd = (ex_mem.mem_op == core_pkg::MEM_LOAD) ? load_data : ex_mem.alu_result;

  always_ff @(posedge clock) begin
    if (mem_go && ex_mem.mem_op == core_pkg::MEM_STORE) begin
      dmem[dmem_index] <= ex_mem.store_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid <= 1'b0;
      halted       <= 1'b0;
    end else begin
      commit_valid <= mem_go;
      if (mem_go && ex_mem.trap) begin
        halted <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (mem_go) begin
      commit <= '{pc: ex_mem.pc, inst: ex_mem.inst, rd: ex_mem.rd, rd_we: ex_mem.rd_we,
                  rd_data: ex_mem_fwd, trap: ex_mem.trap};
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    (ex_mem_valid && ex_mem.mem_op != core_pkg::MEM_NONE) |-> ex_mem.alu_result[1:0] == 2'b00)
    else $error("misaligned data memory access");

endmodule

//--- hw/regfile.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module regfile (
  input  logic                clock,
  input  logic                reset,
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  output core_pkg::word_t     rs1_data,
  output core_pkg::word_t     rs2_data,
  input  logic                wr_en,
  input  core_pkg::reg_addr_t wr_addr,
  input  core_pkg::word_t     wr_data
);

  localparam int NUM_REGS = 2 ** `CORE_REG_ADDR_W;

  core_pkg::word_t regs [NUM_REGS];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  function automatic core_pkg::word_t read_port(core_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    // write in flight this cycle wins
    if (wr_en && wr_addr == addr) begin
      return wr_data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  assert property (@(posedge clock) disable iff (reset) regs[0] == '0)
    else $error("x0 holds a nonzero value");

endmodule

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module core_tb || exit 1

output="$(./obj_dir/Vcore_tb)"
echo "$output"
echo "$output" | grep -qx "=== PASS ===" && exit 0 || exit 1

//--- sim/core_cases.txt
// test count, then per test: test id, program length, commit count; the program words;
// one commit record per line: pc, rd, rd data (checked only when rd is not x0), trap
00000004
00000000 00000006 00000006
00500093 00308113 002081b3 40118233 403082b3 0000006b
00000000 00000001 00000005 00000000
00000004 00000002 00000008 00000000
00000008 00000003 0000000d 00000000
0000000c 00000004 00000008 00000000
00000010 00000005 fffffff8 00000000
00000014 00000000 00000000 00000001
00000001 00000008 00000008
04000093 12300113 0020a223 0040a183 00218233 0040a283 00428333 0000006b
00000000 00000001 00000040 00000000
00000004 00000002 00000123 00000000
00000008 00000000 00000000 00000000
0000000c 00000003 00000123 00000000
00000010 00000004 00000246 00000000
00000014 00000005 00000123 00000000
00000018 00000006 00000369 00000000
0000001c 00000000 00000000 00000001
00000002 00000009 00000007
00700093 00700113 00208663 00100193 00200213 00300293 00508463 00428313 0000006b
00000000 00000001 00000007 00000000
00000004 00000002 00000007 00000000
00000008 00000000 00000000 00000000
00000014 00000005 00000003 00000000
00000018 00000000 00000000 00000000
0000001c 00000006 00000007 00000000
00000020 00000000 00000000 00000001
00000003 00000005 00000004
00900013 01100093 00100133 0000006b 00100193
00000000 00000000 00000000 00000000
00000004 00000001 00000011 00000000
00000008 00000002 00000011 00000000
0000000c 00000000 00000000 00000001

//--- sim/core_tb.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module core_tb;

  localparam int CASE_WORDS       = 256;
  localparam int IMEM_WORDS       = 64;
  localparam int RESET_CYCLES     = 8;
  localparam int POST_HALT_CYCLES = 8;

  logic              clock;
  logic              reset;
  core_pkg::word_t   imem_addr;
  core_pkg::inst_t   imem_data;
  logic              commit_valid;
  core_pkg::commit_t commit;
  logic              halted;

  logic [31:0]     case_words [CASE_WORDS];
  core_pkg::inst_t imem [IMEM_WORDS];
  int              prog_len     = 0;
  int              cycle_count  = 0;
  int              cycle_limit  = 0;
  int              errors       = 0;
  int              tests_failed = 0;

  core_top u_core_top (
    .clock(clock),
    .reset(reset),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .commit_valid(commit_valid),
    .commit(commit),
    .halted(halted)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // words past the loaded program read as trap
  always_comb begin
    if (imem_addr < core_pkg::word_t'(4 * prog_len)) begin
      imem_data = imem[imem_addr[7:2]];
    end else begin
      imem_data = {25'd0, `CORE_TRAP_OPCODE};
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: the run did not end within %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic string test_name(input int id);
    case (id)
      0:       return "alu_chain";
      1:       return "load_store";
      2:       return "branch";
      3:       return "x0_and_halt";
      default: return "unknown";
    endcase
  endfunction

  function automatic int count_commits(input int num_tests);
    int pos;
    int total;
    pos = 1;
    total = 0;
    for (int t = 0; t < num_tests; t++) begin
      total += int'(case_words[pos + 2]);
      pos += 3 + int'(case_words[pos + 1]) + 4 * int'(case_words[pos + 2]);
    end
    return total;
  endfunction

  // program word at a byte address, trap past the end
  function automatic core_pkg::inst_t program_word(input int base, input int len,
                                                   input core_pkg::word_t addr);
    if (addr[1:0] == 2'b00 && addr < core_pkg::word_t'(4 * len)) begin
      return case_words[base + int'(addr[31:2])];
    end
    return {25'd0, `CORE_TRAP_OPCODE};
  endfunction

  // OP, OP-IMM and LOAD write rd
  function automatic logic writes_register(input core_pkg::inst_t inst);
    case (inst[6:0])
      7'b0110011, 7'b0010011, 7'b0000011: return 1'b1;
      default:                            return 1'b0;
    endcase
  endfunction

  task automatic report_mismatch(input string test, input string field, input int idx,
                                 input logic [31:0] expected, input logic [31:0] actual);
    $display("ERROR %s commit %0d %s: expected %h, actual %h",
             test, idx, field, expected, actual);
    errors++;
  endtask

  task automatic run_test(inout int pos);
    int                  num_commits;
    int                  got;
    int                  errors_before;
    int                  rec;
    int                  prog_base;
    string               name;
    core_pkg::word_t     exp_pc;
    core_pkg::reg_addr_t exp_rd;
    core_pkg::word_t     exp_data;
    logic                exp_trap;
    core_pkg::inst_t     exp_inst;
    logic                exp_we;
    name = test_name(int'(case_words[pos]));
    num_commits = int'(case_words[pos + 2]);
    errors_before = errors;
    @(posedge clock);
    reset <= 1'b1;
    prog_len = int'(case_words[pos + 1]);
    for (int i = 0; i < prog_len; i++) begin
      imem[i] = case_words[pos + 3 + i];
    end
    prog_base = pos + 3;
    rec = pos + 3 + prog_len;
    pos = rec + 4 * num_commits;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    if (commit_valid || halted) begin
      $display("%s: commit_valid or halted is high right after reset", name);
      errors++;
    end
    got = 0;
    while (got < num_commits) begin
      @(negedge clock);
      if (commit_valid) begin
        exp_pc   = case_words[rec];
        exp_rd   = case_words[rec + 1][4:0];
        exp_data = case_words[rec + 2];
        exp_trap = case_words[rec + 3][0];
        exp_inst = program_word(prog_base, prog_len, exp_pc);
        exp_we   = writes_register(exp_inst);
        rec += 4;
        if (commit.pc !== exp_pc) begin
          report_mismatch(name, "pc", got, exp_pc, commit.pc);
        end
        if (commit.inst !== exp_inst) begin
          report_mismatch(name, "inst", got, exp_inst, commit.inst);
        end
        if (commit.rd !== exp_rd) begin
          report_mismatch(name, "rd", got, 32'(exp_rd), 32'(commit.rd));
        end
        if (commit.rd_we !== exp_we) begin
          report_mismatch(name, "rd_we", got, 32'(exp_we), 32'(commit.rd_we));
        end
        // x0 results are not architectural
        if (exp_rd != '0 && commit.rd_data !== exp_data) begin
          report_mismatch(name, "rd_data", got, exp_data, commit.rd_data);
        end
        if (commit.trap !== exp_trap) begin
          report_mismatch(name, "trap", got, 32'(exp_trap), 32'(commit.trap));
        end
        if (halted !== exp_trap) begin
          report_mismatch(name, "halted", got, 32'(exp_trap), 32'(halted));
        end
        got++;
      end else if (halted) begin
        $display("%s: core halted with %0d commits still expected", name, num_commits - got);
        errors++;
        break;
      end
    end
    repeat (POST_HALT_CYCLES) begin
      @(negedge clock);
      if (commit_valid) begin
        $display("%s: commit at pc %h after the trap instruction", name, commit.pc);
        errors++;
      end
      if (!halted) begin
        $display("%s: halted dropped after the trap instruction", name);
        errors++;
      end
    end
    if (errors != errors_before) begin
      tests_failed++;
    end
    $display("test %s: %0d of %0d commits seen, %s", name, got, num_commits,
             (errors == errors_before) ? "passed" : "failed");
  endtask

  initial begin
    int pos;
    int num_tests;
    reset <= 1'b1;
    $readmemh("sim/core_cases.txt", case_words);
    if ($isunknown(case_words[0])) begin
      $display("could not read the test cases file");
      $display("=== FAIL ===");
    end else begin
      num_tests = int'(case_words[0]);
      cycle_limit = 8 * count_commits(num_tests) + 100;
      pos = 1;
      for (int t = 0; t < num_tests; t++) begin
        run_test(pos);
      end
      $display("%0d tests run, %0d failed, %0d errors", num_tests, tests_failed, errors);
      if (errors == 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+hw
hw/core_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/regfile.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/core_top.sv
sim/core_tb.sv
